//--- logic/lpf_fifo.sv
// Four-phase handshake FIFO
`timescale 1ns/100ps

module lpf_fifo #(
    parameter type T     = logic [17:0],
    parameter int  DEPTH = 4
) (
    input  logic reset,
    input  logic clk,
    input  logic push,
    input  T     push_data,
    output logic full,
    output logic drop,
    output logic req,
    input  logic ack,
    output T     data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Circular pointer step
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ------------------------------------------------
    // Push side
    // ------------------------------------------------
    assign full    = (count == CNT_W'(DEPTH));
    // Push into a full FIFO is lost
    assign drop    = push && full;
    assign do_push = push && !full;

    always_ff @(posedge reset) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ------------------------------------------------
    // Pop side
    // ------------------------------------------------
    // Head entry goes out with req
    assign data   = mem[rd_ptr];
    // Entry leaves when req falls on ack
    assign do_pop = req && ack;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            req    <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                req    <= 1'b0;
                rd_ptr <= next_ptr(rd_ptr);
            end else if (!req && !ack && (count != '0)) begin
                // Next request only after the previous ack dropped
                req <= 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Head entry holds while the consumer latches it
    assert property (@(posedge reset) disable iff (clk) req |=> !req || $stable(data));
    // No new request until the consumer released ack
    assert property (@(posedge reset) disable iff (clk) !req && ack |=> !req);

endmodule

//--- logic/lpf_param_ctrl.sv
// MIDI cutoff and resonance decoder
`timescale 1ns/100ps

module lpf_param_ctrl #(
    parameter logic [3:0] MIDI_CH = 4'd0
) (
    input  logic               reset,
    input  logic               clk,
    input  logic               midi_rdy,
    input  lpf_pkg::midi_cmd_t midi_cmd,
    input  logic [3:0]         midi_ch,
    input  logic [6:0]         midi_data0,
    input  logic [6:0]         midi_data1,
    output logic               coef_push,
    output lpf_pkg::coef_t     coef_data,
    input  logic               coef_full
);
    import lpf_pkg::*;

    // Current controller values
    logic [6:0] cutoff;
    logic [6:0] resonance;
    // Update waiting for FIFO space
    logic       pending;

    logic       cc_hit;
    logic       hit_cutoff;
    logic       hit_resonance;

    // ------------------------------------------------
    // Message decode
    // ------------------------------------------------
    // Control change on our channel
    assign cc_hit = midi_rdy && (midi_cmd == MIDI_CMD_CC) && (midi_ch == MIDI_CH);

    // Only two controllers matter here
    assign hit_cutoff    = cc_hit && (midi_data0 == CC_CUTOFF);
    assign hit_resonance = cc_hit && (midi_data0 == CC_RESONANCE);

    // ------------------------------------------------
    // Controller registers
    // ------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cutoff    <= CUTOFF_RESET;
            resonance <= RESONANCE_RESET;
            pending   <= 1'b0;
        end else begin
            if (hit_cutoff) begin
                cutoff <= midi_data1;
            end
            if (hit_resonance) begin
                resonance <= midi_data1;
            end
            // New message keeps the update pending even if a push goes out now
            if (hit_cutoff || hit_resonance) begin
                pending <= 1'b1;
            end else if (coef_push) begin
                pending <= 1'b0;
            end
        end
    end

    // ------------------------------------------------
    // Coefficient push
    // ------------------------------------------------
    // Always the newest values
    assign coef_data = calc_coef(cutoff, resonance);
    // Hold off while the FIFO is full
    assign coef_push = pending && !coef_full;

    // FIFO fills only through our own pushes
    assert property (@(posedge reset) disable iff (clk) $rose(coef_full) |-> $past(coef_push));

endmodule

//--- logic/lpf_pkg.sv
// Low-pass filter shared definitions
package lpf_pkg;

    // Fraction bits of samples and coefficients
    localparam int FRAC_BITS = 16;

    // Q1.16 signed audio sample
    typedef logic signed [17:0] sample_t;

    // Q2.16 unsigned coefficient
    typedef logic [17:0] coef_val_t;

    // Frequency and damping coefficient pair
    typedef struct packed {
        coef_val_t f;
        coef_val_t q;
    } coef_t;

    // MIDI command codes as delivered by the parser
    typedef enum logic [2:0] {
        MIDI_CMD_NONE       = 3'd0,
        MIDI_CMD_NOTE_ON    = 3'd1,
        MIDI_CMD_NOTE_OFF   = 3'd2,
        MIDI_CMD_CC         = 3'd3,
        MIDI_CMD_PITCH_BEND = 3'd4,
        MIDI_CMD_SYSEX      = 3'd5
    } midi_cmd_t;

    // Controller numbers
    localparam logic [6:0] CC_CUTOFF    = 7'd74;
    localparam logic [6:0] CC_RESONANCE = 7'd71;

    // Saturation limits
    localparam sample_t SAMPLE_MAX = 18'sh1ffff;
    localparam sample_t SAMPLE_MIN = 18'sh20000;

    // Controller values out of reset
    localparam logic [6:0] CUTOFF_RESET    = 7'd127;
    localparam logic [6:0] RESONANCE_RESET = 7'd0;

    // Linear map from controller values to coefficients
    function automatic coef_t calc_coef(input logic [6:0] cutoff, input logic [6:0] resonance);
        coef_t c;
        c.f = (coef_val_t'(cutoff) + 18'd1) << 9;
        c.q = 18'd131071 - (coef_val_t'(resonance) << 10);
        return c;
    endfunction

    // Coefficients matching the reset controller values
    localparam coef_t COEF_RESET = calc_coef(CUTOFF_RESET, RESONANCE_RESET);

endpackage

//--- logic/lpf_svf_core.sv
// State-variable low-pass filter core
`timescale 1ns/100ps

module lpf_svf_core (
    input  logic             reset,
    input  logic             clk,
    input  logic             s_req,
    output logic             s_ack,
    input  lpf_pkg::sample_t s_data,
    input  logic             c_req,
    output logic             c_ack,
    input  lpf_pkg::coef_t   c_data,
    output logic             sample_out_rdy,
    output lpf_pkg::sample_t sample_out,
    output logic             err_overflow
);
    import lpf_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_COEF, ST_MUL1, ST_MUL2, ST_MUL3, ST_OUT, ST_WAIT
    } state_t;

    // Sum limits widened to the adder width
    localparam logic signed [21:0] SUM_MAX = SAMPLE_MAX;
    localparam logic signed [21:0] SUM_MIN = SAMPLE_MIN;

    state_t             state;
    coef_t              coef;
    // Latched input and filter state
    sample_t            x_in;
    sample_t            low;
    sample_t            band;
    sample_t            high;
    logic               ovf_acc;
    // Shared multiplier
    logic signed [17:0] mul_a;
    logic signed [17:0] mul_b;
    logic signed [35:0] prod;
    logic signed [19:0] prod_sh;
    logic signed [21:0] sum_low;
    logic signed [21:0] sum_high;
    logic signed [21:0] sum_band;
    logic               take_coef;
    logic               take_sample;

    function automatic sample_t sat(input logic signed [21:0] v);
        if (v > SUM_MAX) begin
            return SAMPLE_MAX;
        end else if (v < SUM_MIN) begin
            return SAMPLE_MIN;
        end
        return v[17:0];
    endfunction

    function automatic logic clipped(input logic signed [21:0] v);
        return (v > SUM_MAX) || (v < SUM_MIN);
    endfunction

    // Coefficient update has priority over the next sample
    assign take_coef   = (state == ST_IDLE) && c_req;
    assign take_sample = (state == ST_IDLE) && !c_req && s_req;

    // ------------------------------------------------
    // Multiplier and adders
    // ------------------------------------------------
    // f*band, then q*band, then f*high
    always_comb begin
        mul_a = $signed(coef.f);
        mul_b = band;
        case (state)
            ST_MUL2: mul_a = $signed(coef.q);
            ST_MUL3: mul_b = high;
            default: mul_b = band;
        endcase
    end

    // Truncating shift back to Q1.16
    assign prod_sh  = $signed(prod[35:FRAC_BITS]);
    assign sum_low  = low + prod_sh;
    // Uses the low value updated one step earlier
    assign sum_high = x_in - low - prod_sh;
    assign high     = sat(sum_high);
    assign sum_band = band + prod_sh;

    always_ff @(posedge reset) begin
        prod <= mul_a * mul_b;
        if (take_sample) begin
            x_in <= s_data;
        end
    end

    // ------------------------------------------------
    // Sequencer
    // ------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state          <= ST_IDLE;
            s_ack          <= 1'b0;
            c_ack          <= 1'b0;
            coef           <= COEF_RESET;
            low            <= '0;
            band           <= '0;
            ovf_acc        <= 1'b0;
            err_overflow   <= 1'b0;
            sample_out     <= '0;
            sample_out_rdy <= 1'b0;
        end else begin
            sample_out_rdy <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (take_coef) begin
                        coef  <= c_data;
                        c_ack <= 1'b1;
                        state <= ST_COEF;
                    end else if (take_sample) begin
                        s_ack        <= 1'b1;
                        ovf_acc      <= 1'b0;
                        err_overflow <= 1'b0;
                        state        <= ST_MUL1;
                    end
                end
                // Finish the coefficient handshake
                ST_COEF: begin
                    if (!c_req) begin
                        c_ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                ST_MUL1: state <= ST_MUL2;
                ST_MUL2: begin
                    low     <= sat(sum_low);
                    ovf_acc <= ovf_acc | clipped(sum_low);
                    state   <= ST_MUL3;
                end
                ST_MUL3: begin
                    ovf_acc <= ovf_acc | clipped(sum_high);
                    state   <= ST_OUT;
                end
                // Band update and result out
                ST_OUT: begin
                    band           <= sat(sum_band);
                    sample_out     <= low;
                    sample_out_rdy <= 1'b1;
                    err_overflow   <= ovf_acc | clipped(sum_band);
                    state          <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (!s_req) begin
                        s_ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One pulse per sample
    assert property (@(posedge reset) disable iff (clk) sample_out_rdy |=> !sample_out_rdy);

endmodule

//--- logic/lpf_top.sv
// Resonant low-pass filter top level
`timescale 1ns/100ps

module lpf_top #(
    parameter logic [3:0] MIDI_CH      = 4'd0,
    parameter int         SAMPLE_DEPTH = 4,
    parameter int         COEF_DEPTH   = 2
) (
    input  logic               reset,
    input  logic               clk,
    input  logic               midi_rdy,
    input  lpf_pkg::midi_cmd_t midi_cmd,
    input  logic [3:0]         midi_ch,
    input  logic [6:0]         midi_data0,
    input  logic [6:0]         midi_data1,
    input  logic               sample_in_rdy,
    input  lpf_pkg::sample_t   sample_in,
    output logic               sample_out_rdy,
    output lpf_pkg::sample_t   sample_out,
    output logic               err_overflow,
    output logic               sample_drop
);
    import lpf_pkg::*;

    // Controller to coefficient FIFO
    logic    coef_push;
    coef_t   coef_data;
    logic    coef_full;
    // Coefficient FIFO to core
    logic    c_req;
    logic    c_ack;
    coef_t   c_data;
    // Sample FIFO to core
    logic    s_req;
    logic    s_ack;
    sample_t s_data;

    // ------------------------------------------------
    // Parameter path
    // ------------------------------------------------
    lpf_param_ctrl #(
        .MIDI_CH (MIDI_CH)
    ) param_ctrl_i (
        .reset      (reset),
        .clk        (clk),
        .midi_rdy   (midi_rdy),
        .midi_cmd   (midi_cmd),
        .midi_ch    (midi_ch),
        .midi_data0 (midi_data0),
        .midi_data1 (midi_data1),
        .coef_push  (coef_push),
        .coef_data  (coef_data),
        .coef_full  (coef_full)
    );

    // Controller never pushes when full so drop stays open
    lpf_fifo #(
        .T     (coef_t),
        .DEPTH (COEF_DEPTH)
    ) coef_fifo_i (
        .reset     (reset),
        .clk       (clk),
        .push      (coef_push),
        .push_data (coef_data),
        .full      (coef_full),
        .drop      (),
        .req       (c_req),
        .ack       (c_ack),
        .data      (c_data)
    );

    // ------------------------------------------------
    // Sample path
    // ------------------------------------------------
    lpf_fifo #(
        .T     (sample_t),
        .DEPTH (SAMPLE_DEPTH)
    ) sample_fifo_i (
        .reset     (reset),
        .clk       (clk),
        .push      (sample_in_rdy),
        .push_data (sample_in),
        .full      (),
        .drop      (sample_drop),
        .req       (s_req),
        .ack       (s_ack),
        .data      (s_data)
    );

    lpf_svf_core svf_core_i (
        .reset          (reset),
        .clk            (clk),
        .s_req          (s_req),
        .s_ack          (s_ack),
        .s_data         (s_data),
        .c_req          (c_req),
        .c_ack          (c_ack),
        .c_data         (c_data),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out),
        .err_overflow   (err_overflow)
    );

endmodule

//--- sim.f
logic/lpf_pkg.sv
logic/lpf_param_ctrl.sv
logic/lpf_fifo.sv
logic/lpf_svf_core.sv
logic/lpf_top.sv
verification/lpf_tb.sv

//--- verification/lpf_tb.sv
// Low-pass filter testbench
`timescale 1ns/100ps

module lpf_tb;
    import lpf_pkg::*;

    localparam logic [3:0] MIDI_CH      = 4'd3;
    localparam int         RESET_CYCLES = 16;
    localparam int         IDLE_CYCLES  = 20;
    localparam int         N_RAND       = 200;
    localparam int         N_CC         = 60;
    localparam int         N_SAT        = 100;
    localparam int         N_BURST      = 8;
    localparam int         BURST_LEN    = 10;
    localparam int         N_SAMPLES    = N_RAND + N_CC + N_SAT + N_BURST * BURST_LEN;
    localparam int         N_MIDI       = N_CC + 2;
    // Generous budget per sample and per message
    localparam int         CYCLE_LIMIT  = N_SAMPLES * 20 + N_MIDI * 10 + RESET_CYCLES
                                          + IDLE_CYCLES;

    // Clock is the port named reset, reset the port named clk
    logic       reset;
    logic       clk;
    logic       midi_rdy;
    midi_cmd_t  midi_cmd;
    logic [3:0] midi_ch;
    logic [6:0] midi_data0;
    logic [6:0] midi_data1;
    logic       sample_in_rdy;
    sample_t    sample_in;
    logic       sample_out_rdy;
    sample_t    sample_out;
    logic       err_overflow;
    logic       sample_drop;

    // Error counters
    int         mismatches;
    int         other_errors;
    int         cycle_count;
    int         drops_total;
    int         ovf_expected;
    string      test_name;
    logic [15:0] lfsr;

    // Reference model state
    longint     m_low;
    longint     m_band;
    longint     m_f;
    longint     m_q;
    logic [6:0] m_cutoff;
    logic [6:0] m_resonance;
    sample_t    exp_q[$];
    logic       exp_ovf_q[$];

    lpf_top #(
        .MIDI_CH      (MIDI_CH),
        .SAMPLE_DEPTH (4),
        .COEF_DEPTH   (2)
    ) dut_i (
        .reset          (reset),
        .clk            (clk),
        .midi_rdy       (midi_rdy),
        .midi_cmd       (midi_cmd),
        .midi_ch        (midi_ch),
        .midi_data0     (midi_data0),
        .midi_data1     (midi_data1),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out),
        .err_overflow   (err_overflow),
        .sample_drop    (sample_drop)
    );

    // ------------------------------------------------
    // Random source and model helpers
    // ------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic longint clamp(input longint v);
        if (v > 131071) begin
            return 131071;
        end else if (v < -131072) begin
            return -131072;
        end
        return v;
    endfunction

    function automatic logic out_of_range(input longint v);
        return (v > 131071) || (v < -131072);
    endfunction

    // Linear controller map
    task automatic update_coefs();
        m_f = (longint'(m_cutoff) + 1) * 512;
        m_q = 131071 - longint'(m_resonance) * 1024;
    endtask

    // One filter step, truncating shifts by 16
    task automatic model_step(input sample_t x);
        longint s;
        longint high;
        logic   ovf;
        s      = m_low + ((m_f * m_band) >>> 16);
        ovf    = out_of_range(s);
        m_low  = clamp(s);
        s      = longint'(x) - m_low - ((m_q * m_band) >>> 16);
        ovf    = ovf | out_of_range(s);
        high   = clamp(s);
        s      = m_band + ((m_f * high) >>> 16);
        ovf    = ovf | out_of_range(s);
        m_band = clamp(s);
        if (ovf) begin
            ovf_expected++;
        end
        exp_q.push_back(sample_t'(m_low));
        exp_ovf_q.push_back(ovf);
    endtask

    // ------------------------------------------------
    // Compare tasks
    // ------------------------------------------------
    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // ------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------
    // Lands 1 ns after a rising edge
    task automatic step_cycle();
        @(posedge reset);
        #1;
    endtask

    task automatic send_midi(input midi_cmd_t cmd, input logic [3:0] ch,
                             input logic [6:0] d0, input logic [6:0] d1);
        midi_rdy   = 1'b1;
        midi_cmd   = cmd;
        midi_ch    = ch;
        midi_data0 = d0;
        midi_data1 = d1;
        step_cycle();
        midi_rdy = 1'b0;
        if (cmd == MIDI_CMD_CC && ch == MIDI_CH) begin
            if (d0 == CC_CUTOFF) begin
                m_cutoff = d1;
            end else if (d0 == CC_RESONANCE) begin
                m_resonance = d1;
            end
        end
        update_coefs();
        // Room for the coefficient handshake
        repeat (8) step_cycle();
    endtask

    // Drop decision read mid-cycle
    task automatic push_sample(input sample_t x, input logic must_accept);
        sample_in_rdy = 1'b1;
        sample_in     = x;
        @(negedge reset);
        if (must_accept) begin
            check_flag({test_name, " sample_drop"}, 1'b0, sample_drop);
        end
        if (sample_drop) begin
            drops_total++;
        end else begin
            model_step(x);
        end
        step_cycle();
        sample_in_rdy = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            step_cycle();
        end
        step_cycle();
    endtask

    // ------------------------------------------------
    // Clock, reset and timeout
    // ------------------------------------------------
    initial begin
        reset = 1'b0;
        forever #5 reset = ~reset;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge reset);
            cycle_count++;
        end
        other_errors++;
        $display("Run timed out after %0d cycles", CYCLE_LIMIT);
        report_and_finish();
    end

    // Output monitor against the model queue
    always @(negedge reset) begin
        if (sample_drop && !sample_in_rdy) begin
            other_errors++;
            $display("sample_drop pulsed without a pushed sample");
        end
        if (sample_out_rdy) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("%s: output appeared with no sample pending", test_name);
            end else begin
                check_sample({test_name, " sample_out"}, exp_q.pop_front(), sample_out);
                check_flag({test_name, " err_overflow"}, exp_ovf_q.pop_front(), err_overflow);
            end
        end
    end

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        int         mag;
        int         kind;
        int         burst_drops;
        int         ovf_before;
        logic [3:0] ch;
        logic [6:0] d0;
        mismatches    = 0;
        other_errors  = 0;
        drops_total   = 0;
        ovf_expected  = 0;
        lfsr          = 16'd1488;
        test_name     = "reset";
        clk           = 1'b1;
        midi_rdy      = 1'b0;
        midi_cmd      = MIDI_CMD_NONE;
        midi_ch       = 4'd0;
        midi_data0    = 7'd0;
        midi_data1    = 7'd0;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        m_low         = 0;
        m_band        = 0;
        m_cutoff      = 7'd127;
        m_resonance   = 7'd0;
        update_coefs();
        repeat (RESET_CYCLES) @(posedge reset);
        #1;
        clk = 1'b0;

        // Quiet outputs after reset
        repeat (IDLE_CYCLES) begin
            @(negedge reset);
            check_flag("idle sample_out_rdy", 1'b0, sample_out_rdy);
            check_flag("idle err_overflow", 1'b0, err_overflow);
            check_flag("idle sample_drop", 1'b0, sample_drop);
        end
        step_cycle();

        // Reset coefficients, one sample at a time
        test_name = "random_samples";
        repeat (N_RAND) begin
            push_sample(sample_t'(rand_bits(18)), 1'b1);
            wait_drained();
        end

        // Mixed control changes, only matching ones count
        test_name = "cc_response";
        repeat (N_CC) begin
            kind = int'(rand_bits(3) % 5);
            case (kind)
                0: send_midi(MIDI_CMD_CC, MIDI_CH, CC_CUTOFF, 7'(rand_bits(7)));
                1: send_midi(MIDI_CMD_CC, MIDI_CH, CC_RESONANCE, 7'(rand_bits(7)));
                2: begin
                    ch = MIDI_CH + 4'd1 + 4'(rand_bits(4) % 15);
                    send_midi(MIDI_CMD_CC, ch, CC_CUTOFF, 7'(rand_bits(7)));
                end
                3: begin
                    d0 = 7'(rand_bits(7));
                    if (d0 == CC_CUTOFF || d0 == CC_RESONANCE) begin
                        d0 = 7'd1;
                    end
                    send_midi(MIDI_CMD_CC, MIDI_CH, d0, 7'(rand_bits(7)));
                end
                default: send_midi(MIDI_CMD_NOTE_ON, MIDI_CH, CC_CUTOFF, 7'(rand_bits(7)));
            endcase
            push_sample(sample_t'(rand_bits(18)), 1'b1);
            wait_drained();
        end

        // Full scale input with heavy resonance
        test_name = "saturation";
        ovf_before = ovf_expected;
        send_midi(MIDI_CMD_CC, MIDI_CH, CC_RESONANCE, 7'd127);
        send_midi(MIDI_CMD_CC, MIDI_CH, CC_CUTOFF, 7'd64 + 7'(rand_bits(6)));
        repeat (N_SAT) begin
            mag = 131071 - int'(rand_bits(10));
            if (rand_bits(1) == 1) begin
                mag = -mag;
            end
            push_sample(sample_t'(mag), 1'b1);
            wait_drained();
        end
        if (ovf_expected == ovf_before) begin
            other_errors++;
            $display("Saturation samples never drove the filter into overflow");
        end

        // Back to back bursts overrun the sample FIFO
        test_name = "bursts";
        repeat (N_BURST) begin
            burst_drops = drops_total;
            for (int i = 0; i < BURST_LEN; i++) begin
                push_sample(sample_t'(rand_bits(18)), i < 4);
            end
            if (drops_total == burst_drops) begin
                other_errors++;
                $display("A burst of %0d samples dropped none of them", BURST_LEN);
            end
            wait_drained();
        end

        report_and_finish();
    end

endmodule
